// ==== hdl/btb_predictor.sv ====
//=============================
// Direct-mapped branch target buffer with 2-bit counters.
// Lookup is combinational on pc, training comes from execute.
//=============================
`timescale 1ns/1ps

module btb_predictor
#(
   parameter int                       BTB_ENTRIES = frontend_pkg::DEF_BTB_ENTRIES
)
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  frontend_pkg::addr_t         pc,
   btb_upd_if.sink                     upd,
   output logic                        pred_taken,
   output frontend_pkg::addr_t         pred_tgt
);
   import frontend_pkg::*;

   localparam int OFF_W = $clog2(INSN_BYTES);
   localparam int IDX_W = $clog2(BTB_ENTRIES);
   localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

   logic [BTB_ENTRIES-1:0] valid_q;
   logic [TAG_W-1:0]       tag_q [BTB_ENTRIES];
   addr_t                  tgt_q [BTB_ENTRIES];
   ctr_e                   ctr_q [BTB_ENTRIES];

   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W-1:0] wr_idx;
   logic [TAG_W-1:0] rd_tag;
   logic [TAG_W-1:0] wr_tag;
   logic             rd_hit;
   logic             wr_hit;
   logic             wr_alloc;

   function automatic ctr_e ctr_step(input ctr_e cur, input logic up);
      ctr_e nxt;
      case (cur)
         strong_nt: nxt = up ? weak_nt : strong_nt;
         weak_nt:   nxt = up ? weak_t : strong_nt;
         weak_t:    nxt = up ? strong_t : weak_nt;
         default:   nxt = up ? strong_t : weak_t;
      endcase
      return nxt;
   endfunction

   // Word address low bits pick the entry
   assign rd_idx = pc[OFF_W +: IDX_W];
   assign rd_tag = pc[ADDR_W-1 -: TAG_W];
   assign wr_idx = upd.pc[OFF_W +: IDX_W];
   assign wr_tag = upd.pc[ADDR_W-1 -: TAG_W];

   assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
   assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

   assign pred_taken = rd_hit && (ctr_q[rd_idx] == weak_t || ctr_q[rd_idx] == strong_t);
   assign pred_tgt   = tgt_q[rd_idx];

   // Only taken branches earn an entry
   assign wr_alloc = upd.valid && !wr_hit && upd.taken;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         valid_q <= '0;
      else if (wr_alloc)
         valid_q[wr_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (upd.valid && wr_hit)
      begin
         ctr_q[wr_idx] <= ctr_step(ctr_q[wr_idx], upd.taken);
         if (upd.taken)
            tgt_q[wr_idx] <= upd.tgt;
      end
      else if (wr_alloc)
      begin
         tag_q[wr_idx] <= wr_tag;
         tgt_q[wr_idx] <= upd.tgt;
         ctr_q[wr_idx] <= weak_t;
      end
   end

endmodule

// ==== hdl/btb_upd_if.sv ====
//=============================
// Resolved branch updates from execute toward the predictor.
//=============================
`timescale 1ns/1ps

interface btb_upd_if;
   import frontend_pkg::*;

   logic  valid;
   // Address of the resolved branch
   addr_t pc;
   logic  taken;
   // Actual target, meaningful when taken
   addr_t tgt;

   modport sink (input valid, input pc, input taken, input tgt);

endinterface

// ==== hdl/fetch_push_if.sv ====
//=============================
// Fetched instruction handoff from the bus master into the queue.
// Fetch side uses src, queue side uses dst.
//=============================
`timescale 1ns/1ps

interface fetch_push_if;
   import frontend_pkg::*;

   logic  valid;
   addr_t pc;
   insn_t insn;
   logic  pred_taken;
   // Queue has room for one more entry
   logic  ready;

   modport src (output valid, output pc, output insn, output pred_taken, input ready);

   modport dst (input valid, input pc, input insn, input pred_taken, output ready);

endinterface

// ==== hdl/frontend.sv ====
//=============================
// Instruction fetch front end top level.
// PC, predictor, Wishbone fetch and decode queue.
//=============================
`timescale 1ns/1ps

module frontend
#(
   parameter frontend_pkg::addr_t      PC_RST      = frontend_pkg::DEF_PC_RST,
   parameter int                       IQ_DEPTH    = frontend_pkg::DEF_IQ_DEPTH,
   parameter int                       BTB_ENTRIES = frontend_pkg::DEF_BTB_ENTRIES
)
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        flush,
   input  frontend_pkg::addr_t         flush_tgt,
   // Decode
   output logic                        id_valid,
   input  logic                        id_pop,
   output frontend_pkg::insn_t         id_insn,
   output frontend_pkg::addr_t         id_pc,
   output logic                        id_pred_taken,
   // Branch resolution from execute
   input  logic                        bpu_wb,
   input  frontend_pkg::addr_t         bpu_wb_pc,
   input  logic                        bpu_wb_taken,
   input  frontend_pkg::addr_t         bpu_wb_tgt,
   // Wishbone
   output logic                        ibus_cyc,
   output logic                        ibus_stb,
   output frontend_pkg::addr_t         ibus_adr,
   input  logic                        ibus_ack,
   input  frontend_pkg::insn_t         ibus_dat
);
   import frontend_pkg::*;

   addr_t pc;
   addr_t pred_tgt;
   logic  pred_taken;
   logic  fetch_done;

   fetch_push_if push_if ();
   btb_upd_if    upd_if ();

   assign upd_if.valid = bpu_wb;
   assign upd_if.pc    = bpu_wb_pc;
   assign upd_if.taken = bpu_wb_taken;
   assign upd_if.tgt   = bpu_wb_tgt;

   npc_gen #(.PC_RST(PC_RST)) npc_i
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .flush_tgt  (flush_tgt),
      .fetch_done (fetch_done),
      .pred_taken (pred_taken),
      .pred_tgt   (pred_tgt),
      .pc         (pc)
   );

   btb_predictor #(.BTB_ENTRIES(BTB_ENTRIES)) btb_i
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .pc         (pc),
      .upd        (upd_if.sink),
      .pred_taken (pred_taken),
      .pred_tgt   (pred_tgt)
   );

   ibus_fetch fetch_i
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .pc         (pc),
      .pred_taken (pred_taken),
      .pred_tgt   (pred_tgt),
      .ibus_ack   (ibus_ack),
      .ibus_dat   (ibus_dat),
      .fetch_done (fetch_done),
      .ibus_cyc   (ibus_cyc),
      .ibus_stb   (ibus_stb),
      .ibus_adr   (ibus_adr),
      .push       (push_if.src)
   );

   insn_queue #(.IQ_DEPTH(IQ_DEPTH)) iq_i
   (
      .clk           (clk),
      .arst_n        (arst_n),
      .flush         (flush),
      .push          (push_if.dst),
      .id_pop        (id_pop),
      .id_valid      (id_valid),
      .id_insn       (id_insn),
      .id_pc         (id_pc),
      .id_pred_taken (id_pred_taken)
   );

endmodule

// ==== hdl/frontend_pkg.sv ====
//=============================
// Shared widths, types and defaults for the instruction fetch front end.
// Modules import it in their body and use scoped names in their headers.
//=============================

package frontend_pkg;

   // Address and instruction widths
   localparam int ADDR_W     = 32;
   localparam int INSN_BYTES = 4;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [31:0]       insn_t;

   // 2-bit saturating branch counter
   typedef enum logic [1:0]
   {
      strong_nt = 2'd0,
      weak_nt   = 2'd1,
      weak_t    = 2'd2,
      strong_t  = 2'd3
   } ctr_e;

   // Bus master states
   typedef enum logic
   {
      idle = 1'b0,
      busy = 1'b1
   } fetch_state_e;

   // Defaults picked up by the top level
   localparam addr_t DEF_PC_RST      = 32'h0000_1000;
   localparam int    DEF_IQ_DEPTH    = 4;
   localparam int    DEF_BTB_ENTRIES = 16;

endpackage

// ==== hdl/ibus_fetch.sv ====
//=============================
// Wishbone classic read master, one instruction per bus cycle.
// Ack data goes straight into the queue in the same cycle.
//=============================
`timescale 1ns/1ps

module ibus_fetch
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        flush,
   input  frontend_pkg::addr_t         pc,
   input  logic                        pred_taken,
   input  frontend_pkg::addr_t         pred_tgt,
   input  logic                        ibus_ack,
   input  frontend_pkg::insn_t         ibus_dat,
   output logic                        fetch_done,
   output logic                        ibus_cyc,
   output logic                        ibus_stb,
   output frontend_pkg::addr_t         ibus_adr,
   fetch_push_if.src                   push
);
   import frontend_pkg::*;

   localparam int OFF_W = $clog2(INSN_BYTES);

   fetch_state_e state_q;
   logic         kill_q;
   addr_t        adr_q;
   logic         start;
   logic         accept;

   // Start only with a free queue slot so the ack always has room
   assign start  = (state_q == idle) && push.ready && !flush;
   assign accept = (state_q == busy) && ibus_ack && !kill_q && !flush;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state_q <= idle;
         kill_q  <= 1'b0;
      end
      else if (state_q == idle)
      begin
         if (start)
         begin
            state_q <= busy;
            kill_q  <= 1'b0;
         end
      end
      else if (ibus_ack)
      begin
         state_q <= idle;
         kill_q  <= 1'b0;
      end
      else if (flush)
      begin
         // Data of this cycle is stale
         kill_q <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
         adr_q <= {pc[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
   end

   assign ibus_cyc = (state_q == busy);
   assign ibus_stb = (state_q == busy);
   assign ibus_adr = adr_q;

   assign push.valid      = accept;
   assign push.pc         = adr_q;
   assign push.insn       = ibus_dat;
   assign push.pred_taken = pred_taken;

   assign fetch_done = accept;

endmodule

// ==== hdl/insn_queue.sv ====
//=============================
// Prefetch FIFO between fetch and decode.
// Pop frees a slot at the same edge, flush empties it.
//=============================
`timescale 1ns/1ps

module insn_queue
#(
   parameter int                       IQ_DEPTH = frontend_pkg::DEF_IQ_DEPTH
)
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        flush,
   fetch_push_if.dst                   push,
   input  logic                        id_pop,
   output logic                        id_valid,
   output frontend_pkg::insn_t         id_insn,
   output frontend_pkg::addr_t         id_pc,
   output logic                        id_pred_taken
);
   import frontend_pkg::*;

   localparam int PW = $clog2(IQ_DEPTH);

   addr_t pc_mem   [IQ_DEPTH];
   insn_t insn_mem [IQ_DEPTH];
   logic  pt_mem   [IQ_DEPTH];

   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;
   logic          do_push;
   logic          do_pop;

   assign push.ready = (count < (PW+1)'(IQ_DEPTH));
   assign id_valid   = (count != '0);

   // Flush beats both push and pop
   assign do_push = push.valid && push.ready && !flush;
   assign do_pop  = id_valid && id_pop && !flush;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (flush)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + PW'(1);
         if (do_pop)
            rd_ptr <= rd_ptr + PW'(1);
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         pc_mem[wr_ptr]   <= push.pc;
         insn_mem[wr_ptr] <= push.insn;
         pt_mem[wr_ptr]   <= push.pred_taken;
      end
   end

   // Head of queue
   assign id_pc         = pc_mem[rd_ptr];
   assign id_insn       = insn_mem[rd_ptr];
   assign id_pred_taken = pt_mem[rd_ptr];

endmodule

// ==== hdl/npc_gen.sv ====
//=============================
// Program counter register and next PC selection.
// Flush has priority over a completed fetch.
//=============================
`timescale 1ns/1ps

module npc_gen
#(
   parameter frontend_pkg::addr_t      PC_RST = frontend_pkg::DEF_PC_RST
)
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        flush,
   input  frontend_pkg::addr_t         flush_tgt,
   input  logic                        fetch_done,
   input  logic                        pred_taken,
   input  frontend_pkg::addr_t         pred_tgt,
   output frontend_pkg::addr_t         pc
);
   import frontend_pkg::*;

   addr_t pc_nxt;

   // Redirect or step
   always_comb
   begin
      pc_nxt = pc;
      if (flush)
      begin
         pc_nxt = flush_tgt;
      end
      else if (fetch_done)
      begin
         if (pred_taken)
            pc_nxt = pred_tgt;
         else
            pc_nxt = pc + addr_t'(INSN_BYTES);
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         pc <= PC_RST;
      else
         pc <= pc_nxt;
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the front end testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module frontend_tb -f verilog.f -o frontend_sim
./obj_dir/frontend_sim | tee sim.log

if grep -q "^sim passed$" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

// ==== verif/frontend_tb.sv ====
//=============================
// Testbench for the fetch front end. A Wishbone memory model adds random
// wait states, a step table drives flushes, branch updates and decode pops,
// and a reference model checks every entry that decode takes.
//=============================
`timescale 1ns/1ps

module frontend_tb;
   import frontend_pkg::*;

   localparam int    CLK_PERIOD = 4;
   localparam int    IQ_DEPTH   = DEF_IQ_DEPTH;
   localparam insn_t INSN_XOR   = 32'h5a5a_0000;

   // One table row; addr is the flush target or the branch address
   typedef struct packed
   {
      logic  flush;
      logic  upd;
      logic  taken;
      addr_t addr;
      addr_t tgt;
      logic  pop;
      logic  sync_cyc;
      int    n_items;
      int    cycles;
      addr_t exp0;
      addr_t exp1;
   } step_t;

   logic  clk;
   logic  arst_n;
   logic  flush;
   addr_t flush_tgt;
   logic  id_pop;
   logic  bpu_wb;
   addr_t bpu_wb_pc;
   logic  bpu_wb_taken;
   addr_t bpu_wb_tgt;
   logic  ibus_ack;
   insn_t ibus_dat;
   logic  id_valid;
   insn_t id_insn;
   addr_t id_pc;
   logic  id_pred_taken;
   logic  ibus_cyc;
   logic  ibus_stb;
   addr_t ibus_adr;

   step_t       steps [$];
   int          step_idx;
   logic        table_built;
   int unsigned lcg_state = 32'hfd95;

   // Reference model state that only the monitor updates
   addr_t exp_pc    = DEF_PC_RST;
   ctr_e  m_ctr [addr_t];
   addr_t m_tgt [addr_t];
   int    occ       = 0;
   int    occ_prev  = 0;
   logic  cyc_prev  = 1'b0;
   logic  ack_prev  = 1'b0;
   logic  killed    = 1'b0;
   int    delivered = 0;
   int    step_cnt  = 0;
   int    last_step = -1;
   int    n_checks  = 0;
   int    n_errors  = 0;

   frontend dut_i (.*);

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic btb_says_taken(input addr_t p);
      return m_ctr.exists(p) && (m_ctr[p] == weak_t || m_ctr[p] == strong_t);
   endfunction

   function automatic addr_t next_pc(input addr_t p);
      if (btb_says_taken(p))
         return m_tgt[p];
      return p + addr_t'(INSN_BYTES);
   endfunction

   task automatic train_model(input addr_t pc, input logic taken, input addr_t tgt);
      if (m_ctr.exists(pc))
      begin
         if (taken)
         begin
            m_tgt[pc] = tgt;
            if (m_ctr[pc] != strong_t)
               m_ctr[pc] = ctr_e'(m_ctr[pc] + 2'd1);
         end
         else if (m_ctr[pc] != strong_nt)
            m_ctr[pc] = ctr_e'(m_ctr[pc] - 2'd1);
      end
      else if (taken)
      begin
         m_ctr[pc] = weak_t;
         m_tgt[pc] = tgt;
      end
   endtask

   task automatic check_pc(input string name, input addr_t got, input addr_t exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_insn(input string name, input insn_t got, input insn_t exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic add_step(input logic fl, input logic up, input logic tk, input addr_t ad,
                           input addr_t tg, input logic pp, input logic sc, input int n,
                           input int cyc, input addr_t e0, input addr_t e1);
      steps.push_back('{fl, up, tk, ad, tg, pp, sc, n, cyc, e0, e1});
   endtask

   task automatic build_table();
      // Sequential stream from the reset vector
      add_step(1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 1'b1, 1'b0, 6, 8, 32'h1000, 32'h1004);
      // Fill with decode stalled, then drain
      add_step(1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 0, 10, 32'h0, 32'h0);
      add_step(1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 1'b1, 1'b0, 8, 8, 32'h0, 32'h0);
      // Two flushes with the second one inside a bus cycle
      add_step(1'b1, 1'b0, 1'b0, 32'h1800, 32'h0, 1'b1, 1'b0, 4, 8, 32'h1800, 32'h1804);
      add_step(1'b1, 1'b0, 1'b0, 32'h1c00, 32'h0, 1'b1, 1'b1, 4, 8, 32'h1c00, 32'h1c04);
      // Taken branch at 0x2000 to 0x3000
      add_step(1'b0, 1'b1, 1'b1, 32'h2000, 32'h3000, 1'b0, 1'b0, 0, 4, 32'h0, 32'h0);
      add_step(1'b1, 1'b0, 1'b0, 32'h2000, 32'h0, 1'b1, 1'b0, 4, 8, 32'h2000, 32'h3000);
      // Two not-taken outcomes bring the counter below the threshold
      add_step(1'b0, 1'b1, 1'b0, 32'h2000, 32'h0, 1'b0, 1'b0, 0, 2, 32'h0, 32'h0);
      add_step(1'b0, 1'b1, 1'b0, 32'h2000, 32'h0, 1'b0, 1'b0, 0, 2, 32'h0, 32'h0);
      add_step(1'b1, 1'b0, 1'b0, 32'h2000, 32'h0, 1'b1, 1'b0, 4, 8, 32'h2000, 32'h2004);
      add_step(1'b1, 1'b0, 1'b0, 32'h1000, 32'h0, 1'b1, 1'b0, 10, 8, 32'h1000, 32'h1004);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Wishbone slave returning the address folded with a constant
   initial
   begin : wb_slave
      int wait_left;
      wait_left = -1;
      ibus_ack  = 1'b0;
      ibus_dat  = '0;
      forever
      begin
         @(posedge clk);
         #1;
         if (ibus_ack)
         begin
            ibus_ack = 1'b0;
         end
         else if (ibus_cyc && ibus_stb)
         begin
            if (wait_left < 0)
               wait_left = int'((lcg_next() >> 16) % 32'd4);
            if (wait_left == 0)
            begin
               ibus_ack  = 1'b1;
               ibus_dat  = ibus_adr ^ INSN_XOR;
               wait_left = -1;
            end
            else
               wait_left--;
         end
      end
   end

   // Reference queue and bus checks sampled mid-cycle
   always @(negedge clk)
   begin : monitor
      logic pushing;
      logic popping;
      if (arst_n)
      begin
         if (ibus_cyc && !cyc_prev && occ_prev >= IQ_DEPTH)
         begin
            n_errors++;
            $display("t=%0t a bus cycle started while the queue was full", $time);
         end
         check_bit("ibus_stb", ibus_stb, ibus_cyc);
         if (cyc_prev && !ack_prev && !ibus_cyc)
         begin
            n_errors++;
            $display("t=%0t a bus cycle ended without an ack", $time);
         end
         if (cyc_prev && ack_prev && ibus_cyc)
         begin
            n_errors++;
            $display("t=%0t a bus cycle started right after an ack", $time);
         end
         check_bit("id_valid", id_valid, occ != 0);
         popping = id_valid && id_pop && !flush;
         pushing = ibus_cyc && ibus_ack && !killed && !flush;
         if (popping)
         begin
            if (step_idx != last_step)
            begin
               step_cnt  = 0;
               last_step = step_idx;
            end
            check_pc("id_pc", id_pc, exp_pc);
            check_insn("id_insn", id_insn, exp_pc ^ INSN_XOR);
            check_bit("id_pred_taken", id_pred_taken, btb_says_taken(exp_pc));
            if (step_cnt == 0 && steps[step_idx].exp0 != '0)
               check_pc("id_pc first in step", id_pc, steps[step_idx].exp0);
            if (step_cnt == 1 && steps[step_idx].exp1 != '0)
               check_pc("id_pc second in step", id_pc, steps[step_idx].exp1);
            exp_pc = next_pc(exp_pc);
            step_cnt++;
            delivered++;
         end
         occ_prev = occ;
         cyc_prev = ibus_cyc;
         ack_prev = ibus_ack;
         if (flush)
         begin
            occ    = 0;
            exp_pc = flush_tgt;
         end
         else
         begin
            if (pushing)
               occ++;
            if (popping)
               occ--;
         end
         // Data of a cycle hit by a flush is dropped at its ack
         if (ibus_cyc && ibus_ack)
            killed = 1'b0;
         else if (ibus_cyc && flush)
            killed = 1'b1;
         if (bpu_wb)
            train_model(bpu_wb_pc, bpu_wb_taken, bpu_wb_tgt);
      end
   end

   initial
   begin : watchdog
      int budget;
      budget = 0;
      wait (table_built);
      foreach (steps[i])
         budget += steps[i].cycles;
      #(budget * 8 * CLK_PERIOD);
      $display("watchdog expired after %0d clock cycles", budget * 8);
      $display("sim failed");
      $finish;
   end

   initial
   begin : driver
      step_t st;
      int    base;
      int    s;
      table_built  = 1'b0;
      arst_n       = 1'b0;
      flush        = 1'b0;
      flush_tgt    = '0;
      id_pop       = 1'b0;
      bpu_wb       = 1'b0;
      bpu_wb_pc    = '0;
      bpu_wb_taken = 1'b0;
      bpu_wb_tgt   = '0;
      step_idx     = 0;
      build_table();
      table_built = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;
      for (s = 0; s < steps.size(); s++)
      begin
         st = steps[s];
         while (st.sync_cyc && !ibus_cyc)
         begin
            @(posedge clk);
            #1;
         end
         step_idx = s;
         base     = delivered;
         id_pop   = st.pop;
         if (st.flush)
         begin
            flush     = 1'b1;
            flush_tgt = st.addr;
         end
         if (st.upd)
         begin
            bpu_wb       = 1'b1;
            bpu_wb_pc    = st.addr;
            bpu_wb_taken = st.taken;
            bpu_wb_tgt   = st.tgt;
         end
         @(posedge clk);
         #1;
         flush  = 1'b0;
         bpu_wb = 1'b0;
         // Wait for decode to take its entries or for a stalled queue to fill
         while (st.pop ? (delivered - base < st.n_items) : !(occ == IQ_DEPTH && !ibus_cyc))
         begin
            @(posedge clk);
            #1;
         end
         repeat (st.cycles)
         begin
            @(posedge clk);
            #1;
         end
         $display("step %0d done, %0d entries taken by decode, %0d errors so far",
                  s, delivered - base, n_errors);
      end
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
hdl/frontend_pkg.sv
hdl/fetch_push_if.sv
hdl/btb_upd_if.sv
hdl/npc_gen.sv
hdl/btb_predictor.sv
hdl/ibus_fetch.sv
hdl/insn_queue.sv
hdl/frontend.sv
verif/frontend_tb.sv
